// File: bench/i2cSlaveModel.sv
`timescale 1ns/1ps

module i2cSlaveModel (
    input  logic [6:0] devAddr,
    input  logic       i2cClk,
    inout  wire        i2cData
);

    logic [7:0] regs [0:15];
    logic sdaLow;
    logic active;
    logic reading;
    logic ackPhase;
    logic masterAck;
    logic [7:0] shiftIn;
    logic [7:0] shiftOut;
    logic [3:0] regPtr;
    int bitCnt;
    int byteIdx;

    // Open drain, the pull-up sits on the bench
    assign i2cData = sdaLow ? 1'b0 : 1'bz;

    initial begin
        sdaLow = 1'b0;
        active = 1'b0;
        reading = 1'b0;
        ackPhase = 1'b0;
        masterAck = 1'b0;
        shiftIn = '0;
        shiftOut = '0;
        regPtr = '0;
        bitCnt = 0;
        byteIdx = 0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = {4'(i), ~4'(i)};
        end
    end

    // Start or repeated start
    always @(negedge i2cData) begin
        if (i2cClk === 1'b1) begin
            active = 1'b1;
            reading = 1'b0;
            ackPhase = 1'b0;
            bitCnt = 0;
            byteIdx = 0;
            sdaLow = 1'b0;
        end
    end

    // Stop
    always @(posedge i2cData) begin
        if (i2cClk === 1'b1) begin
            active = 1'b0;
            sdaLow = 1'b0;
        end
    end

    always @(posedge i2cClk) begin
        if (active) begin
            if (bitCnt < 8) begin
                shiftIn = {shiftIn[6:0], i2cData === 1'b1};
                bitCnt = bitCnt + 1;
            end else begin
                masterAck = (i2cData === 1'b0);
            end
        end
    end

    always @(negedge i2cClk) begin
        if (active) begin
            if (ackPhase) begin
                // End of the ninth clock
                ackPhase = 1'b0;
                bitCnt = 0;
                sdaLow = 1'b0;
                if (reading && (byteIdx == 1 || masterAck)) begin
                    shiftOut = regs[regPtr];
                    regPtr = regPtr + 4'd1;
                    sdaLow = !shiftOut[7];
                end
            end else if (bitCnt == 8) begin
                ackPhase = 1'b1;
                if (reading) begin
                    sdaLow = 1'b0;      // Master answers this one
                end else begin
                    case (byteIdx)
                        0: begin
                            if (shiftIn[7:1] != devAddr) begin
                                active = 1'b0;
                            end else begin
                                reading = shiftIn[0];
                                sdaLow = 1'b1;
                            end
                        end
                        1: sdaLow = 1'b1;   // High register byte unused
                        2: begin
                            regPtr = shiftIn[3:0];
                            sdaLow = 1'b1;
                        end
                        default: begin
                            regs[regPtr] = shiftIn;
                            regPtr = regPtr + 4'd1;
                            sdaLow = 1'b1;
                        end
                    endcase
                end
                byteIdx = byteIdx + 1;
            end else if (reading && bitCnt > 0) begin
                sdaLow = !shiftOut[7 - bitCnt];
            end
        end
    end

endmodule

// File: bench/pixI2cAssert.sv
`timescale 1ns/1ps

module pixI2cAssert (
    input logic                    clk,
    input logic                    rstN,
    input logic                    i2cClk,
    input logic                    i2cData,
    input logic                    statusDone,
    input logic                    statusErr,
    input logic                    pending,
    input pixI2cPkg::masterStateT  masterState
);
    import pixI2cPkg::*;

    // Failed assertion count
    int failCount = 0;

    // Data edges under a high clock come from start, repeated start or stop only
    property dataHeldWhileClkHigh;
        @(posedge clk) disable iff (!rstN)
            (i2cClk && $past(i2cClk) && $changed(i2cData))
            |-> (masterState inside {StStartClkLow, StRestartClkLow, StStopDone});
    endproperty

    property errOnlyWithDone;
        @(posedge clk) disable iff (!rstN)
            $changed(statusErr) |-> $changed(statusDone);
    endproperty

    property clkHighWhenIdle;
        @(posedge clk) disable iff (!rstN)
            (masterState == StIdle && !pending) |-> i2cClk;
    endproperty

    assert property (dataHeldWhileClkHigh)
        else begin
            $error("data line moved while the bus clock was high");
            failCount++;
        end
    assert property (errOnlyWithDone)
        else begin
            $error("statusErr changed without a statusDone toggle");
            failCount++;
        end
    assert property (clkHighWhenIdle)
        else begin
            $error("bus clock low while the master is idle");
            failCount++;
        end

endmodule

bind pixI2cTop pixI2cAssert busChecks (
    .clk(clk),
    .rstN(rstN),
    .i2cClk(i2cClk),
    .i2cData(i2cData),
    .statusDone(statusDone),
    .statusErr(statusErr),
    .pending(cmdBus.pending),
    .masterState(master.state)
);

// File: bench/pixI2cTb.sv
`timescale 1ns/1ps

module pixI2cTb;
    import pixI2cPkg::*;

    localparam int ClkPeriod = 100;
    localparam int ResetCycles = 8;
    localparam int InputDelay = 10;
    localparam int NumCommands = 6;
    // Worst case is a two-byte read of about 226 steps
    localparam int CmdSteps = 260;
    localparam int CmdCycles = CmdSteps * (QuarterDelay + 1);
    localparam slaveAddrT SensorAddr = 7'h3C;

    logic clk;
    logic rstN;
    slaveAddrT cmdSlaveAddr;
    logic cmdWrite;
    regAddrT cmdRegAddr;
    regDataT cmdWriteData;
    logic cmdDataLen;
    logic cmdTrigger;
    logic statusDone;
    logic statusErr;
    regDataT statusReadData;
    logic i2cClk;
    wire i2cData;
    int errorCount;
    int checkCount;

    pullup (i2cData);

    pixI2cTop uut (
        .clk(clk),
        .rstN(rstN),
        .cmdSlaveAddr(cmdSlaveAddr),
        .cmdWrite(cmdWrite),
        .cmdRegAddr(cmdRegAddr),
        .cmdWriteData(cmdWriteData),
        .cmdDataLen(cmdDataLen),
        .cmdTrigger(cmdTrigger),
        .statusDone(statusDone),
        .statusErr(statusErr),
        .statusReadData(statusReadData),
        .i2cClk(i2cClk),
        .i2cData(i2cData)
    );

    i2cSlaveModel slave (
        .devAddr(SensorAddr),
        .i2cClk(i2cClk),
        .i2cData(i2cData)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((ResetCycles + NumCommands * 2 * CmdCycles + 100) * ClkPeriod);
        $display("Watchdog expired at %0t, the tests did not finish", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Post one command and wait for the done toggle
    task automatic runCommand(input slaveAddrT addr, input logic write,
                              input regAddrT regAddr, input regDataT data,
                              input logic len);
        logic doneBefore;
        int waitCycles;
        @(posedge clk);
        #InputDelay;
        cmdSlaveAddr = addr;
        cmdWrite = write;
        cmdRegAddr = regAddr;
        cmdWriteData = data;
        cmdDataLen = len;
        doneBefore = statusDone;
        cmdTrigger = ~cmdTrigger;
        waitCycles = 0;
        while (statusDone === doneBefore && waitCycles < 2 * CmdCycles) begin
            @(negedge clk);
            waitCycles++;
        end
        if (statusDone === doneBefore) begin
            errorCount++;
            $display("Command to address 0x%0h timed out, statusDone never toggled", addr);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic checkResetState();
        checkValue("i2cClk", i2cClk, 1'b1);
        checkValue("i2cData", i2cData, 1'b1);
        checkValue("statusDone", statusDone, 1'b0);
        checkValue("statusErr", statusErr, 1'b0);
    endtask

    task automatic writeTwoBytes();
        regAddrT regAddr;
        regDataT data;
        logic [3:0] idx;
        regAddr = 16'($urandom());
        data = 16'($urandom());
        idx = regAddr[3:0];
        runCommand(SensorAddr, 1'b1, regAddr, data, 1'b1);
        checkValue("statusErr", statusErr, 1'b0);
        checkValue($sformatf("slave.regs[%0d]", idx), slave.regs[idx], data[15:8]);
        checkValue($sformatf("slave.regs[%0d]", idx + 4'd1), slave.regs[idx + 4'd1],
                   data[7:0]);
    endtask

    task automatic writeOneByte();
        regAddrT regAddr;
        regDataT data;
        logic [3:0] idx;
        logic [7:0] nextByte;
        logic [7:0] prevByte;
        regAddr = 16'($urandom());
        data = 16'($urandom());
        idx = regAddr[3:0];
        nextByte = slave.regs[idx + 4'd1];
        prevByte = slave.regs[idx - 4'd1];
        runCommand(SensorAddr, 1'b1, regAddr, data, 1'b0);
        checkValue("statusErr", statusErr, 1'b0);
        checkValue($sformatf("slave.regs[%0d]", idx), slave.regs[idx], data[7:0]);
        checkValue($sformatf("slave.regs[%0d]", idx + 4'd1), slave.regs[idx + 4'd1],
                   nextByte);
        checkValue($sformatf("slave.regs[%0d]", idx - 4'd1), slave.regs[idx - 4'd1],
                   prevByte);
    endtask

    task automatic readTwoBytes();
        regAddrT regAddr;
        logic [3:0] idx;
        logic [7:0] hiByte;
        logic [7:0] loByte;
        regAddr = 16'($urandom());
        idx = regAddr[3:0];
        hiByte = 8'($urandom());
        loByte = 8'($urandom());
        slave.regs[idx] = hiByte;
        slave.regs[idx + 4'd1] = loByte;
        runCommand(SensorAddr, 1'b0, regAddr, 16'h0000, 1'b1);
        checkValue("statusErr", statusErr, 1'b0);
        checkValue("statusReadData", statusReadData, {hiByte, loByte});
    endtask

    task automatic readOneByte();
        regAddrT regAddr;
        logic [3:0] idx;
        logic [7:0] value;
        regAddr = 16'($urandom());
        idx = regAddr[3:0];
        value = 8'($urandom());
        slave.regs[idx] = value;
        runCommand(SensorAddr, 1'b0, regAddr, 16'h0000, 1'b0);
        checkValue("statusErr", statusErr, 1'b0);
        checkValue("statusReadData[7:0]", statusReadData[7:0], value);
    endtask

    // NACKed address followed by a good command that clears the error
    task automatic wrongAddressNack();
        logic [7:0] snapshot [0:15];
        slaveAddrT badAddr;
        for (int i = 0; i < 16; i++) begin
            snapshot[i] = slave.regs[i];
        end
        badAddr = SensorAddr ^ 7'($urandom_range(127, 1));
        runCommand(badAddr, 1'b1, 16'($urandom()), 16'($urandom()), 1'b1);
        checkValue("statusErr", statusErr, 1'b1);
        for (int i = 0; i < 16; i++) begin
            checkValue($sformatf("slave.regs[%0d]", i), slave.regs[i], snapshot[i]);
        end
        readOneByte();
    endtask

    initial begin
        void'($urandom(32'hb955_1743));
        errorCount = 0;
        checkCount = 0;
        rstN = 1'b0;
        cmdSlaveAddr = '0;
        cmdWrite = 1'b0;
        cmdRegAddr = '0;
        cmdWriteData = '0;
        cmdDataLen = 1'b0;
        cmdTrigger = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #InputDelay;
        rstN = 1'b1;
        @(negedge clk);

        checkResetState();
        writeTwoBytes();
        writeOneByte();
        readTwoBytes();
        readOneByte();
        wrongAddressNack();

        errorCount += uut.busChecks.failCount;
        $display("Run complete: %0d checks, %0d assertion failures, %0d errors",
                 checkCount, uut.busChecks.failCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src/cmdIntake.sv
`timescale 1ns/1ps

module cmdIntake (
    input  logic                 clk,
    input  logic                 rstN,
    input  pixI2cPkg::slaveAddrT cmdSlaveAddr,
    input  logic                 cmdWrite,
    input  pixI2cPkg::regAddrT   cmdRegAddr,
    input  pixI2cPkg::regDataT   cmdWriteData,
    input  logic                 cmdDataLen,
    input  logic                 cmdTrigger,
    pixCmdIf.intake              cmd
);

    logic [1:0] trigSync;
    logic trigSeen;
    logic trigChanged;

    // Toggle parity differs from the last accepted one
    assign trigChanged = trigSync[1] ^ trigSeen;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            trigSync <= 2'b00;
            trigSeen <= 1'b0;
            cmd.pending <= 1'b0;
        end else begin
            trigSync <= {trigSync[0], cmdTrigger};
            if (cmd.accept) begin
                cmd.pending <= 1'b0;
                trigSeen <= ~trigSeen;
            end else begin
                // A second toggle before accept restores parity and drops the request
                cmd.pending <= trigChanged;
            end
        end
    end

    // Fields frozen while the request waits
    always_ff @(posedge clk) begin
        if (trigChanged && !cmd.pending) begin
            cmd.slaveAddr <= cmdSlaveAddr;
            cmd.write <= cmdWrite;
            cmd.regAddr <= cmdRegAddr;
            cmd.writeData <= cmdWriteData;
            cmd.dataLen <= cmdDataLen;
        end
    end

endmodule

// File: src/i2cMaster.sv
`timescale 1ns/1ps

module i2cMaster (
    input  logic               clk,
    input  logic               rstN,
    pixCmdIf.master            cmd,
    output logic               sclOut,
    output logic               sdaOut,
    input  logic               sdaIn,
    output logic               statusDone,
    output logic               statusErr,
    output pixI2cPkg::regDataT statusReadData
);
    import pixI2cPkg::*;

    masterStateT state;
    masterStateT nextState;
    delayT delay;
    logic [8:0] outShift;       // Low bit is the sentinel
    logic [16:0] inShift;       // Sentinel walks up to bit 16
    logic [16:0] inNext;
    logic hostAck;
    logic failed;

    // Command copy held for the whole transaction
    slaveAddrT addrLat;
    logic writeLat;
    regAddrT regAddrLat;
    regDataT dataLat;
    logic lenLat;

    assign sdaOut = outShift[8];
    assign inNext = {inShift[15:0], sdaIn};

    always_ff @(posedge clk) begin
        if (state == StIdle && delay == '0 && cmd.pending) begin
            addrLat <= cmd.slaveAddr;
            writeLat <= cmd.write;
            regAddrLat <= cmd.regAddr;
            dataLat <= cmd.writeData;
            lenLat <= cmd.dataLen;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= StIdle;
            nextState <= StIdle;
            delay <= '0;
            sclOut <= 1'b1;
            outShift <= '1;
            failed <= 1'b0;
            cmd.accept <= 1'b0;
            statusDone <= 1'b0;
            statusErr <= 1'b0;
        end else begin
            cmd.accept <= 1'b0;
            if (delay != '0) begin
                delay <= delay - delayT'(1);
            end else begin
                delay <= delayT'(QuarterDelay);
                case (state)
                    // ==============================
                    // Start and slave address
                    // ==============================
                    StIdle: begin
                        if (cmd.pending) begin
                            cmd.accept <= 1'b1;
                            outShift <= '0;     // Data falls while clock is high
                            state <= StStartClkLow;
                        end else begin
                            delay <= '0;
                        end
                    end
                    StStartClkLow: begin
                        sclOut <= 1'b0;
                        state <= StStartAddr;
                    end
                    // Always the write direction first, reads turn around later
                    StStartAddr: begin
                        outShift <= {addrLat, 1'b0, 1'b1};
                        nextState <= StRegAddrHi;
                        state <= StShiftHigh;
                    end

                    // ==============================
                    // Byte out and slave ACK
                    // ==============================
                    StShiftHigh: begin
                        sclOut <= 1'b1;
                        state <= StShiftHold;
                    end
                    StShiftHold: state <= StShiftLow;
                    StShiftLow: begin
                        sclOut <= 1'b0;
                        state <= StShiftNext;
                    end
                    StShiftNext: begin
                        if (outShift[7:0] != 8'b1000_0000) begin
                            outShift <= outShift << 1;
                            state <= StShiftHigh;
                        end else begin
                            outShift <= '1;     // Hand the line to the slave
                            state <= StAckHigh;
                        end
                    end
                    StAckHigh: begin
                        sclOut <= 1'b1;
                        state <= StAckHold;
                    end
                    StAckHold: state <= StAckCheck;
                    // Sampled at the end of the second high quarter
                    StAckCheck: begin
                        sclOut <= 1'b0;
                        state <= sdaIn ? StStopFail : nextState;
                    end

                    // ==============================
                    // Register address and write data
                    // ==============================
                    StRegAddrHi: begin
                        outShift <= {regAddrLat[15:8], 1'b1};
                        nextState <= StRegAddrLo;
                        state <= StShiftHigh;
                    end
                    StRegAddrLo: begin
                        outShift <= {regAddrLat[7:0], 1'b1};
                        state <= StShiftHigh;
                        if (!writeLat) begin
                            nextState <= StRestartRelease;
                        end else if (lenLat) begin
                            nextState <= StWriteHi;
                        end else begin
                            nextState <= StWriteLo;
                        end
                    end
                    StWriteHi: begin
                        outShift <= {dataLat[15:8], 1'b1};
                        nextState <= StWriteLo;
                        state <= StShiftHigh;
                    end
                    StWriteLo: begin
                        outShift <= {dataLat[7:0], 1'b1};
                        nextState <= StStopOk;
                        state <= StShiftHigh;
                    end

                    // ==============================
                    // Repeated start and read
                    // ==============================
                    StRestartRelease: begin
                        outShift <= '1;
                        state <= StRestartHigh;
                    end
                    StRestartHigh: begin
                        sclOut <= 1'b1;
                        state <= StRestartStart;
                    end
                    StRestartStart: begin
                        outShift <= '0;
                        state <= StRestartClkLow;
                    end
                    StRestartClkLow: begin
                        sclOut <= 1'b0;
                        state <= StRestartAddr;
                    end
                    StRestartAddr: begin
                        outShift <= {addrLat, 1'b1, 1'b1};
                        inShift <= lenLat ? 17'd1 : 17'd256;
                        nextState <= StReadRelease;
                        state <= StShiftHigh;
                    end
                    StReadRelease: begin
                        outShift <= '1;
                        state <= StReadHigh;
                    end
                    StReadHigh: begin
                        sclOut <= 1'b1;
                        state <= StReadHold;
                    end
                    StReadHold: state <= StReadLow;
                    StReadLow: begin
                        sclOut <= 1'b0;
                        inShift <= inNext;
                        if (inNext[16:8] == 9'b0_0000_0001) begin
                            // First of two bytes in, ACK it
                            hostAck <= 1'b1;
                            nextState <= StReadRelease;
                            state <= StHostAckDrive;
                        end else if (inNext[16]) begin
                            hostAck <= 1'b0;
                            nextState <= StStopOk;
                            state <= StHostAckDrive;
                        end else begin
                            state <= StReadRelease;
                        end
                    end
                    StHostAckDrive: begin
                        outShift <= hostAck ? '0 : '1;
                        state <= StHostAckHigh;
                    end
                    StHostAckHigh: begin
                        sclOut <= 1'b1;
                        state <= StHostAckHold;
                    end
                    StHostAckHold: state <= StHostAckLow;
                    StHostAckLow: begin
                        sclOut <= 1'b0;
                        state <= nextState;
                    end

                    // ==============================
                    // Stop and status
                    // ==============================
                    StStopOk: begin
                        failed <= 1'b0;
                        outShift <= '0;
                        state <= StStopHigh;
                    end
                    StStopFail: begin
                        failed <= 1'b1;
                        outShift <= '0;
                        state <= StStopHigh;
                    end
                    StStopHigh: begin
                        sclOut <= 1'b1;
                        state <= StStopRelease;
                    end
                    StStopRelease: begin
                        outShift <= '1;     // Data rises while clock is high
                        state <= StStopDone;
                    end
                    StStopDone: begin
                        statusDone <= ~statusDone;
                        statusErr <= failed;
                        if (!writeLat) begin
                            statusReadData <= inShift[15:0];
                        end
                        state <= StIdle;
                    end
                endcase
            end
        end
    end

endmodule

// File: src/i2cPads.sv
`timescale 1ns/1ps

module i2cPads (
    input  logic clk,
    input  logic rstN,
    input  logic sclOut,
    input  logic sdaOut,
    output logic sdaIn,
    output logic i2cClk,
    inout  wire  i2cData
);

    logic sdaReg;
    logic [1:0] sdaSync;

    // Open drain, only ever pulls low
    assign i2cData = sdaReg ? 1'bz : 1'b0;
    assign sdaIn = sdaSync[1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            i2cClk <= 1'b1;
            sdaReg <= 1'b1;
            sdaSync <= 2'b11;
        end else begin
            i2cClk <= sclOut;
            sdaReg <= sdaOut;
            // Two flops on the pin before the master sees it
            sdaSync <= {sdaSync[0], i2cData};
        end
    end

endmodule

// File: src/pixCmdIf.sv
`timescale 1ns/1ps

interface pixCmdIf;
    import pixI2cPkg::*;

    slaveAddrT slaveAddr;
    logic write;
    regAddrT regAddr;
    regDataT writeData;
    logic dataLen;      // 0 for one byte, 1 for two
    logic pending;
    logic accept;

    modport intake (
        output slaveAddr, write, regAddr, writeData, dataLen, pending,
        input accept
    );

    modport master (
        input slaveAddr, write, regAddr, writeData, dataLen, pending,
        output accept
    );

endinterface

// File: src/pixI2cPkg.sv
package pixI2cPkg;

    // ==============================
    // Bus timing
    // ==============================
    localparam int ClkFreq = 10_000_000;
    localparam int I2cClkFreq = 400_000;

    // Quarter bus period in clk cycles, rounded up so the bus never runs fast
    localparam int QuarterDelay = (ClkFreq + 4 * I2cClkFreq - 1) / (4 * I2cClkFreq) - 1;
    localparam int DelayWidth = $clog2(QuarterDelay + 1);

    // ==============================
    // Types
    // ==============================
    typedef logic [6:0] slaveAddrT;
    typedef logic [15:0] regAddrT;
    typedef logic [15:0] regDataT;
    typedef logic [DelayWidth-1:0] delayT;

    // Master sequencer, one quarter bus period per state
    typedef enum logic [4:0] {
        StIdle, StStartClkLow, StStartAddr,
        StShiftHigh, StShiftHold, StShiftLow, StShiftNext,
        StAckHigh, StAckHold, StAckCheck,
        StRegAddrHi, StRegAddrLo, StWriteHi, StWriteLo,
        StRestartRelease, StRestartHigh, StRestartStart, StRestartClkLow, StRestartAddr,
        StReadRelease, StReadHigh, StReadHold, StReadLow,
        StHostAckDrive, StHostAckHigh, StHostAckHold, StHostAckLow,
        StStopOk, StStopFail, StStopHigh, StStopRelease, StStopDone
    } masterStateT;

endpackage

// File: src/pixI2cTop.sv
`timescale 1ns/1ps

module pixI2cTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  pixI2cPkg::slaveAddrT cmdSlaveAddr,
    input  logic                 cmdWrite,
    input  pixI2cPkg::regAddrT   cmdRegAddr,
    input  pixI2cPkg::regDataT   cmdWriteData,
    input  logic                 cmdDataLen,
    input  logic                 cmdTrigger,
    output logic                 statusDone,
    output logic                 statusErr,
    output pixI2cPkg::regDataT   statusReadData,
    output logic                 i2cClk,
    inout  wire                  i2cData
);

    logic sclOut;
    logic sdaOut;
    logic sdaIn;

    pixCmdIf cmdBus ();

    cmdIntake intake (
        .clk(clk),
        .rstN(rstN),
        .cmdSlaveAddr(cmdSlaveAddr),
        .cmdWrite(cmdWrite),
        .cmdRegAddr(cmdRegAddr),
        .cmdWriteData(cmdWriteData),
        .cmdDataLen(cmdDataLen),
        .cmdTrigger(cmdTrigger),
        .cmd(cmdBus.intake)
    );

    i2cMaster master (
        .clk(clk),
        .rstN(rstN),
        .cmd(cmdBus.master),
        .sclOut(sclOut),
        .sdaOut(sdaOut),
        .sdaIn(sdaIn),
        .statusDone(statusDone),
        .statusErr(statusErr),
        .statusReadData(statusReadData)
    );

    i2cPads pads (
        .clk(clk),
        .rstN(rstN),
        .sclOut(sclOut),
        .sdaOut(sdaOut),
        .sdaIn(sdaIn),
        .i2cClk(i2cClk),
        .i2cData(i2cData)
    );

endmodule

// File: verilog.f
src/pixI2cPkg.sv
src/pixCmdIf.sv
src/cmdIntake.sv
src/i2cMaster.sv
src/i2cPads.sv
src/pixI2cTop.sv
bench/i2cSlaveModel.sv
bench/pixI2cAssert.sv
bench/pixI2cTb.sv
